// File: common/tile_pkg.sv
// Tile-local widths, address map, command opcodes and address views
package tile_pkg;

  localparam int addr_width_lp   = 40;
  localparam int data_width_lp   = 64;
  localparam int dev_width_lp    = 4;
  localparam int offset_width_lp = 20;
  localparam int did_width_lp    = 8;

  // Everything at or above this goes to DRAM
  localparam logic [addr_width_lp-1:0] dram_base_lp = 40'h00_8000_0000;

  // Device numbers in addr[23:20]
  localparam logic [dev_width_lp-1:0] clint_dev_lp = 4'd1;
  localparam logic [dev_width_lp-1:0] cfg_dev_lp   = 4'd2;

  // Interrupt slice offsets
  localparam logic [offset_width_lp-1:0] clint_msip_lp     = 20'h0_0000;
  localparam logic [offset_width_lp-1:0] clint_mtimecmp_lp = 20'h0_4000;
  localparam logic [offset_width_lp-1:0] clint_mtime_lp    = 20'h0_bff8;

  // Configuration offsets
  localparam logic [offset_width_lp-1:0] cfg_freeze_lp = 20'h0_0000;
  localparam logic [offset_width_lp-1:0] cfg_did_lp    = 20'h0_0008;

  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  // Same 40 bits seen as a flat DRAM address or as a local device access
  typedef union packed
  {
    logic [addr_width_lp-1:0] dram;
    struct packed
    {
      logic [addr_width_lp-dev_width_lp-offset_width_lp-1:0] upper;
      logic [dev_width_lp-1:0]                               dev;
      logic [offset_width_lp-1:0]                            offset;
    } loc;
  } mem_addr_u;

endpackage

// File: common/mem_if.sv
// Memory command and response channel interface with master and slave modports
`timescale 1ns/100ps

interface mem_if;
  import tile_pkg::*;

  // Command channel, valid/ready
  logic                     cmd_v;
  logic                     cmd_ready;
  mem_op_e                  cmd_op;
  mem_addr_u                cmd_addr;
  logic [data_width_lp-1:0] cmd_data;

  // Response channel, valid/yumi
  logic                     resp_v;
  logic                     resp_yumi;
  mem_op_e                  resp_op;
  mem_addr_u                resp_addr;
  logic [data_width_lp-1:0] resp_data;

  modport master
  (
    output cmd_v, cmd_op, cmd_addr, cmd_data, resp_yumi,
    input  cmd_ready, resp_v, resp_op, resp_addr, resp_data
  );

  modport slave
  (
    input  cmd_v, cmd_op, cmd_addr, cmd_data, resp_yumi,
    output cmd_ready, resp_v, resp_op, resp_addr, resp_data
  );

endinterface

// File: logic/local_cmd_router.sv
// Local address decode, command fan-out and fixed-priority response arbiter
`timescale 1ns/100ps

module local_cmd_router
(
  input  logic                               clk_i,
  input  logic                               reset_i,

  input  logic                               cmd_v_i,
  input  tile_pkg::mem_op_e                  cmd_op_i,
  input  logic [tile_pkg::addr_width_lp-1:0] cmd_addr_i,
  input  logic [tile_pkg::data_width_lp-1:0] cmd_data_i,
  output logic                               cmd_ready_o,

  output logic                               resp_v_o,
  output tile_pkg::mem_op_e                  resp_op_o,
  output logic [tile_pkg::addr_width_lp-1:0] resp_addr_o,
  output logic [tile_pkg::data_width_lp-1:0] resp_data_o,
  input  logic                               resp_yumi_i,

  mem_if.master                              cfg_bus,
  mem_if.master                              clint_bus,
  mem_if.master                              dram_bus
);
  import tile_pkg::*;

  mem_addr_u addr_li;
  logic      local_li;
  logic      cfg_sel_li;
  logic      clint_sel_li;

  assign addr_li  = cmd_addr_i;
  assign local_li = (addr_li.dram < dram_base_lp);

  assign cfg_sel_li   = local_li & (addr_li.loc.dev == cfg_dev_lp);
  assign clint_sel_li = local_li & (addr_li.loc.dev == clint_dev_lp);

  // Unclaimed local devices fall through to DRAM
  assign cfg_bus.cmd_v   = cmd_v_i & cfg_sel_li;
  assign clint_bus.cmd_v = cmd_v_i & clint_sel_li;
  assign dram_bus.cmd_v  = cmd_v_i & ~cfg_sel_li & ~clint_sel_li;

  assign cfg_bus.cmd_op    = cmd_op_i;
  assign cfg_bus.cmd_addr  = addr_li;
  assign cfg_bus.cmd_data  = cmd_data_i;
  assign clint_bus.cmd_op   = cmd_op_i;
  assign clint_bus.cmd_addr = addr_li;
  assign clint_bus.cmd_data = cmd_data_i;
  assign dram_bus.cmd_op   = cmd_op_i;
  assign dram_bus.cmd_addr = addr_li;
  assign dram_bus.cmd_data = cmd_data_i;

  assign cmd_ready_o = cfg_bus.cmd_ready & clint_bus.cmd_ready & dram_bus.cmd_ready;

  // DRAM wins, then cfg, then clint
  assign dram_bus.resp_yumi  = resp_yumi_i & dram_bus.resp_v;
  assign cfg_bus.resp_yumi   = resp_yumi_i & cfg_bus.resp_v & ~dram_bus.resp_v;
  assign clint_bus.resp_yumi = resp_yumi_i & clint_bus.resp_v & ~dram_bus.resp_v
                               & ~cfg_bus.resp_v;

  assign resp_v_o = dram_bus.resp_v | cfg_bus.resp_v | clint_bus.resp_v;

  always_comb
  begin
    if (dram_bus.resp_v)
    begin
      resp_op_o   = dram_bus.resp_op;
      resp_addr_o = dram_bus.resp_addr;
      resp_data_o = dram_bus.resp_data;
    end
    else if (cfg_bus.resp_v)
    begin
      resp_op_o   = cfg_bus.resp_op;
      resp_addr_o = cfg_bus.resp_addr;
      resp_data_o = cfg_bus.resp_data;
    end
    else
    begin
      resp_op_o   = clint_bus.resp_op;
      resp_addr_o = clint_bus.resp_addr;
      resp_data_o = clint_bus.resp_data;
    end
  end

  a_one_peer_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({cfg_bus.cmd_v, clint_bus.cmd_v, dram_bus.cmd_v}));

  // Upstream only yumis a valid response, so exactly one peer gets the grant
  a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_yumi_i |-> $onehot({cfg_bus.resp_yumi, clint_bus.resp_yumi, dram_bus.resp_yumi}));

endmodule

// File: clint/clint_slice.sv
// Core-local interrupt slice with mtime, mtimecmp and msip registers
`timescale 1ns/100ps

module clint_slice
(
  input  logic clk_i,
  input  logic reset_i,
  mem_if.slave bus,
  output logic timer_irq_o,
  output logic software_irq_o
);
  import tile_pkg::*;

  logic                     resp_v_r;
  mem_op_e                  resp_op_r;
  mem_addr_u                resp_addr_r;
  logic [data_width_lp-1:0] resp_data_r;

  logic [data_width_lp-1:0] mtime_r;
  logic [data_width_lp-1:0] mtimecmp_r;
  logic                     msip_r;

  logic                     cmd_fire_li;
  logic                     wr_li;
  logic [data_width_lp-1:0] rd_data_li;

  assign bus.cmd_ready = ~resp_v_r;
  assign cmd_fire_li   = bus.cmd_v & bus.cmd_ready;
  assign wr_li         = cmd_fire_li & (bus.cmd_op == e_mem_wr);

  always_comb
  begin
    case (bus.cmd_addr.loc.offset)
      clint_msip_lp:     rd_data_li = {{(data_width_lp-1){1'b0}}, msip_r};
      clint_mtimecmp_lp: rd_data_li = mtimecmp_r;
      clint_mtime_lp:    rd_data_li = mtime_r;
      default:           rd_data_li = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resp_v_r   <= 1'b0;
      mtime_r    <= '0;
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
    end
    else
    begin
      if (cmd_fire_li)
        resp_v_r <= 1'b1;
      else if (bus.resp_yumi)
        resp_v_r <= 1'b0;

      // A write to mtime takes precedence over the tick
      if (wr_li && bus.cmd_addr.loc.offset == clint_mtime_lp)
        mtime_r <= bus.cmd_data;
      else
        mtime_r <= mtime_r + 1'b1;

      if (wr_li && bus.cmd_addr.loc.offset == clint_mtimecmp_lp)
        mtimecmp_r <= bus.cmd_data;
      if (wr_li && bus.cmd_addr.loc.offset == clint_msip_lp)
        msip_r <= bus.cmd_data[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire_li)
    begin
      resp_op_r   <= bus.cmd_op;
      resp_addr_r <= bus.cmd_addr;
      resp_data_r <= (bus.cmd_op == e_mem_wr) ? '0 : rd_data_li;
    end
  end

  assign bus.resp_v    = resp_v_r;
  assign bus.resp_op   = resp_op_r;
  assign bus.resp_addr = resp_addr_r;
  assign bus.resp_data = resp_data_r;

  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

  a_no_cmd_while_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    (bus.resp_v && !bus.resp_yumi) |=> !(bus.cmd_v && bus.cmd_ready));

endmodule

// File: cfg/cfg_regs.sv
// Configuration registers for freeze and domain id
`timescale 1ns/100ps

module cfg_regs
(
  input  logic                              clk_i,
  input  logic                              reset_i,
  mem_if.slave                              bus,
  output logic                              freeze_o,
  output logic [tile_pkg::did_width_lp-1:0] did_o
);
  import tile_pkg::*;

  logic                     resp_v_r;
  mem_op_e                  resp_op_r;
  mem_addr_u                resp_addr_r;
  logic [data_width_lp-1:0] resp_data_r;

  logic                     freeze_r;
  logic [did_width_lp-1:0]  did_r;

  logic                     cmd_fire_li;
  logic                     wr_li;
  logic [data_width_lp-1:0] rd_data_li;

  assign bus.cmd_ready = ~resp_v_r;
  assign cmd_fire_li   = bus.cmd_v & bus.cmd_ready;
  assign wr_li         = cmd_fire_li & (bus.cmd_op == e_mem_wr);

  always_comb
  begin
    case (bus.cmd_addr.loc.offset)
      cfg_freeze_lp: rd_data_li = {{(data_width_lp-1){1'b0}}, freeze_r};
      cfg_did_lp:    rd_data_li = {{(data_width_lp-did_width_lp){1'b0}}, did_r};
      default:       rd_data_li = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resp_v_r <= 1'b0;
      freeze_r <= 1'b1;
      did_r    <= '0;
    end
    else
    begin
      if (cmd_fire_li)
        resp_v_r <= 1'b1;
      else if (bus.resp_yumi)
        resp_v_r <= 1'b0;

      if (wr_li && bus.cmd_addr.loc.offset == cfg_freeze_lp)
        freeze_r <= bus.cmd_data[0];
      if (wr_li && bus.cmd_addr.loc.offset == cfg_did_lp)
        did_r <= bus.cmd_data[did_width_lp-1:0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire_li)
    begin
      resp_op_r   <= bus.cmd_op;
      resp_addr_r <= bus.cmd_addr;
      resp_data_r <= (bus.cmd_op == e_mem_wr) ? '0 : rd_data_li;
    end
  end

  assign bus.resp_v    = resp_v_r;
  assign bus.resp_op   = resp_op_r;
  assign bus.resp_addr = resp_addr_r;
  assign bus.resp_data = resp_data_r;

  assign freeze_o = freeze_r;
  assign did_o    = did_r;

  a_no_cmd_while_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    (bus.resp_v && !bus.resp_yumi) |=> !(bus.cmd_v && bus.cmd_ready));

endmodule

// File: logic/dram_port.sv
// Single-outstanding bridge from the local bus to the external memory ports
`timescale 1ns/100ps

module dram_port
(
  input  logic                               clk_i,
  input  logic                               reset_i,
  mem_if.slave                               bus,

  output logic                               mem_cmd_v_o,
  output tile_pkg::mem_op_e                  mem_cmd_op_o,
  output logic [tile_pkg::addr_width_lp-1:0] mem_cmd_addr_o,
  output logic [tile_pkg::data_width_lp-1:0] mem_cmd_data_o,
  input  logic                               mem_cmd_ready_i,

  input  logic                               mem_resp_v_i,
  input  logic [tile_pkg::data_width_lp-1:0] mem_resp_data_i,
  output logic                               mem_resp_ready_o
);
  import tile_pkg::*;

  // One of send, wait, respond is set while busy
  logic                     send_r;
  logic                     wait_r;
  logic                     resp_v_r;

  mem_op_e                  op_r;
  mem_addr_u                addr_r;
  logic [data_width_lp-1:0] data_r;
  logic [data_width_lp-1:0] resp_data_r;

  logic                     cmd_fire_li;

  assign bus.cmd_ready = ~(send_r | wait_r | resp_v_r);
  assign cmd_fire_li   = bus.cmd_v & bus.cmd_ready;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      send_r   <= 1'b0;
      wait_r   <= 1'b0;
      resp_v_r <= 1'b0;
    end
    else
    begin
      if (cmd_fire_li)
        send_r <= 1'b1;
      else if (send_r && mem_cmd_ready_i)
        send_r <= 1'b0;

      if (send_r && mem_cmd_ready_i)
        wait_r <= 1'b1;
      else if (wait_r && mem_resp_v_i)
        wait_r <= 1'b0;

      if (wait_r && mem_resp_v_i)
        resp_v_r <= 1'b1;
      else if (bus.resp_yumi)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire_li)
    begin
      op_r   <= bus.cmd_op;
      addr_r <= bus.cmd_addr;
      data_r <= bus.cmd_data;
    end
    if (wait_r && mem_resp_v_i)
      resp_data_r <= mem_resp_data_i;
  end

  assign mem_cmd_v_o      = send_r;
  assign mem_cmd_op_o     = op_r;
  assign mem_cmd_addr_o   = addr_r.dram;
  assign mem_cmd_data_o   = data_r;
  assign mem_resp_ready_o = wait_r;

  assign bus.resp_v    = resp_v_r;
  assign bus.resp_op   = op_r;
  assign bus.resp_addr = addr_r;
  assign bus.resp_data = resp_data_r;

  a_mem_cmd_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && !mem_cmd_ready_i) |=> mem_cmd_v_o && $stable(mem_cmd_op_o)
      && $stable(mem_cmd_addr_o) && $stable(mem_cmd_data_o));

endmodule

// File: logic/tile_local_top.sv
// Tile-local command path top level with router, cfg, clint and DRAM port
`timescale 1ns/100ps

module tile_local_top
(
  input  logic                               clk_i,
  input  logic                               reset_i,

  input  logic                               cmd_v_i,
  input  tile_pkg::mem_op_e                  cmd_op_i,
  input  logic [tile_pkg::addr_width_lp-1:0] cmd_addr_i,
  input  logic [tile_pkg::data_width_lp-1:0] cmd_data_i,
  output logic                               cmd_ready_o,

  output logic                               resp_v_o,
  output tile_pkg::mem_op_e                  resp_op_o,
  output logic [tile_pkg::addr_width_lp-1:0] resp_addr_o,
  output logic [tile_pkg::data_width_lp-1:0] resp_data_o,
  input  logic                               resp_yumi_i,

  output logic                               mem_cmd_v_o,
  output tile_pkg::mem_op_e                  mem_cmd_op_o,
  output logic [tile_pkg::addr_width_lp-1:0] mem_cmd_addr_o,
  output logic [tile_pkg::data_width_lp-1:0] mem_cmd_data_o,
  input  logic                               mem_cmd_ready_i,

  input  logic                               mem_resp_v_i,
  input  logic [tile_pkg::data_width_lp-1:0] mem_resp_data_i,
  output logic                               mem_resp_ready_o,

  output logic                               freeze_o,
  output logic [tile_pkg::did_width_lp-1:0]  did_o,
  output logic                               timer_irq_o,
  output logic                               software_irq_o
);

  mem_if cfg_bus ();
  mem_if clint_bus ();
  mem_if dram_bus ();

  local_cmd_router router
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_ready_o (cmd_ready_o),
    .resp_v_o    (resp_v_o),
    .resp_op_o   (resp_op_o),
    .resp_addr_o (resp_addr_o),
    .resp_data_o (resp_data_o),
    .resp_yumi_i (resp_yumi_i),
    .cfg_bus     (cfg_bus.master),
    .clint_bus   (clint_bus.master),
    .dram_bus    (dram_bus.master)
  );

  cfg_regs cfg
  (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .bus      (cfg_bus.slave),
    .freeze_o (freeze_o),
    .did_o    (did_o)
  );

  clint_slice clint
  (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .bus            (clint_bus.slave),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

  dram_port dram
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .bus              (dram_bus.slave),
    .mem_cmd_v_o      (mem_cmd_v_o),
    .mem_cmd_op_o     (mem_cmd_op_o),
    .mem_cmd_addr_o   (mem_cmd_addr_o),
    .mem_cmd_data_o   (mem_cmd_data_o),
    .mem_cmd_ready_i  (mem_cmd_ready_i),
    .mem_resp_v_i     (mem_resp_v_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .mem_resp_ready_o (mem_resp_ready_o)
  );

endmodule

// File: tests/tile_tb.sv
// Testbench for the tile-local command path with file stimulus and a memory model
`timescale 1ns/100ps

module tile_tb;
  import tile_pkg::*;

  localparam int max_lines_lp = 64;
  localparam int timeout_lp   = 1000;

  logic                     clk_i;
  logic                     reset_i;
  logic                     cmd_v_i;
  mem_op_e                  cmd_op_i;
  logic [addr_width_lp-1:0] cmd_addr_i;
  logic [data_width_lp-1:0] cmd_data_i;
  logic                     cmd_ready_o;
  logic                     resp_v_o;
  mem_op_e                  resp_op_o;
  logic [addr_width_lp-1:0] resp_addr_o;
  logic [data_width_lp-1:0] resp_data_o;
  logic                     resp_yumi_i;
  logic                     mem_cmd_v_o;
  mem_op_e                  mem_cmd_op_o;
  logic [addr_width_lp-1:0] mem_cmd_addr_o;
  logic [data_width_lp-1:0] mem_cmd_data_o;
  logic                     mem_cmd_ready_i;
  logic                     mem_resp_v_i;
  logic [data_width_lp-1:0] mem_resp_data_i;
  logic                     mem_resp_ready_o;
  logic                     freeze_o;
  logic [did_width_lp-1:0]  did_o;
  logic                     timer_irq_o;
  logic                     software_irq_o;

  // Six words per line: test, op, addr, wdata, expected, mask
  logic [63:0] stim_mem [0:6*max_lines_lp+5];

  int          errors;
  int          checks;
  int          tests;
  int          mem_cmds;
  bit          timed_out;

  mem_op_e     cur_op;
  logic [39:0] cur_addr;
  logic [63:0] cur_data;

  // External memory model state
  logic [63:0] mem_model [logic [39:0]];
  bit          pending;
  mem_op_e     pend_op;
  logic [39:0] pend_addr;
  int unsigned resp_delay;

  // Expected register state of the local peers
  logic        exp_freeze;
  logic [7:0]  exp_did;
  logic        exp_msip;
  logic [63:0] exp_mtimecmp;
  logic [63:0] last_mtime;
  bit          have_mtime;

  tile_local_top dut_i (.*);

  always #5 clk_i = ~clk_i;

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_status();
    check_value("freeze_o", freeze_o, exp_freeze);
    check_value("did_o", did_o, exp_did);
    check_value("software_irq_o", software_irq_o, exp_msip);
    if (exp_mtimecmp == '0)
      check_value("timer_irq_o", timer_irq_o, 1);
    else if (exp_mtimecmp == '1)
      check_value("timer_irq_o", timer_irq_o, 0);
  endtask

  // Answers one memory command at a time after a random delay
  always @(negedge clk_i)
  begin
    mem_resp_v_i = 1'b0;
    if (reset_i)
    begin
      mem_cmd_ready_i = 1'b0;
      pending = 1'b0;
    end
    else
    begin
      // Ready for a response exactly while one is owed
      check_value("mem_resp_ready_o", mem_resp_ready_o, pending);
      if (pending && mem_resp_ready_o)
      begin
        if (resp_delay == 0)
        begin
          mem_resp_v_i = 1'b1;
          if (pend_op == e_mem_wr || !mem_model.exists(pend_addr))
            mem_resp_data_i = '0;
          else
            mem_resp_data_i = mem_model[pend_addr];
          pending = 1'b0;
        end
        else
          resp_delay--;
      end
      mem_cmd_ready_i = ($urandom_range(3) != 0);
      if (!pending && mem_cmd_v_o && mem_cmd_ready_i)
      begin
        mem_cmds++;
        check_value("mem cmd op", mem_cmd_op_o, cur_op);
        check_value("mem cmd addr", mem_cmd_addr_o, cur_addr);
        if (mem_cmd_op_o == e_mem_wr)
        begin
          check_value("mem cmd data", mem_cmd_data_o, cur_data);
          mem_model[mem_cmd_addr_o] = mem_cmd_data_o;
        end
        pending    = 1'b1;
        pend_op    = mem_cmd_op_o;
        pend_addr  = mem_cmd_addr_o;
        resp_delay = $urandom_range(4);
      end
    end
  end

  task automatic run_command(input mem_op_e op, input logic [39:0] addr,
                             input logic [63:0] wdata, input logic [63:0] exp,
                             input logic [63:0] mask);
    int          wait_cnt;
    int          stall;
    int          i;
    int          cmds_before;
    bit          to_dram;
    logic [39:0] held_addr;
    logic [63:0] held_data;

    to_dram = (addr >= 40'h00_8000_0000) || (addr[23:20] != 4'd1 && addr[23:20] != 4'd2);
    cmds_before = mem_cmds;
    wait_cnt = 0;
    while (!cmd_ready_o && wait_cnt < timeout_lp)
    begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (!cmd_ready_o)
    begin
      $display("Timeout: DUT never became ready to accept a command");
      timed_out = 1'b1;
      return;
    end
    cur_op     = op;
    cur_addr   = addr;
    cur_data   = wdata;
    cmd_v_i    = 1'b1;
    cmd_op_i   = op;
    cmd_addr_i = addr;
    cmd_data_i = wdata;
    @(negedge clk_i);
    cmd_v_i = 1'b0;
    wait_cnt = 0;
    while (!resp_v_o && wait_cnt < timeout_lp)
    begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (!resp_v_o)
    begin
      $display("Timeout: no response came back for a command");
      timed_out = 1'b1;
      return;
    end
    // Hold off yumi and watch the response stay put
    held_addr = resp_addr_o;
    held_data = resp_data_o;
    stall = $urandom_range(3);
    for (i = 0; i < stall; i++)
    begin
      @(negedge clk_i);
      check_value("held resp_v", resp_v_o, 1);
      check_value("held resp addr", resp_addr_o, held_addr);
      check_value("held resp data", resp_data_o, held_data);
    end
    check_value("resp op", resp_op_o, op);
    check_value("resp addr", resp_addr_o, addr);
    check_value("resp data", resp_data_o & mask, exp & mask);
    check_value("memory commands", mem_cmds - cmds_before, to_dram ? 1 : 0);
    if (op == e_mem_wr && !to_dram)
    begin
      if (addr[23:20] == 4'd2 && addr[19:0] == 20'h0)
        exp_freeze = wdata[0];
      if (addr[23:20] == 4'd2 && addr[19:0] == 20'h8)
        exp_did = wdata[7:0];
      if (addr[23:20] == 4'd1 && addr[19:0] == 20'h0)
        exp_msip = wdata[0];
      if (addr[23:20] == 4'd1 && addr[19:0] == 20'h4000)
        exp_mtimecmp = wdata;
    end
    if (op == e_mem_rd && !to_dram && addr[23:20] == 4'd1 && addr[19:0] == 20'hbff8)
    begin
      if (have_mtime)
        check_value("mtime increasing", resp_data_o > last_mtime, 1);
      last_mtime = resp_data_o;
      have_mtime = 1'b1;
    end
    check_status();
    resp_yumi_i = 1'b1;
    @(negedge clk_i);
    resp_yumi_i = 1'b0;
  endtask

  initial
  begin
    int          line;
    int          test_errors;
    logic [63:0] cur_test;

    void'($urandom(32'h3b65405c));
    clk_i           = 1'b0;
    reset_i         = 1'b1;
    cmd_v_i         = 1'b0;
    cmd_op_i        = e_mem_rd;
    cmd_addr_i      = '0;
    cmd_data_i      = '0;
    resp_yumi_i     = 1'b0;
    mem_cmd_ready_i = 1'b0;
    mem_resp_v_i    = 1'b0;
    mem_resp_data_i = '0;
    errors          = 0;
    checks          = 0;
    tests           = 0;
    mem_cmds        = 0;
    timed_out       = 1'b0;
    pending         = 1'b0;
    exp_freeze      = 1'b1;
    exp_did         = '0;
    exp_msip        = 1'b0;
    exp_mtimecmp    = '1;
    have_mtime      = 1'b0;
    for (line = 0; line < 6*max_lines_lp+6; line++)
      stim_mem[line] = '0;
    $readmemh("tests/tile_stimulus.txt", stim_mem);

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    check_value("resp_v after reset", resp_v_o, 0);
    check_value("mem_cmd_v after reset", mem_cmd_v_o, 0);
    check_status();

    line        = 0;
    cur_test    = stim_mem[0];
    test_errors = errors;
    while (line < max_lines_lp && stim_mem[6*line] != 0 && !timed_out)
    begin
      run_command(mem_op_e'(stim_mem[6*line+1][0]), stim_mem[6*line+2][39:0],
                  stim_mem[6*line+3], stim_mem[6*line+4], stim_mem[6*line+5]);
      line++;
      if (timed_out || stim_mem[6*line] != cur_test)
      begin
        tests++;
        $display("Test %0d done, %0d errors", cur_test, errors - test_errors);
        test_errors = errors;
        cur_test    = stim_mem[6*line];
      end
    end

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && !timed_out)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: tests/tile_stimulus.txt
// test op addr wdata expected mask  (hex, op 0 = read, 1 = write)
// a test number of 0 ends the list
1 0 0000200000 0 1 ffffffffffffffff
1 0 0000200008 0 0 ffffffffffffffff
1 1 0000200000 0 0 ffffffffffffffff
1 1 0000200008 5a 0 ffffffffffffffff
1 0 0000200000 0 0 ffffffffffffffff
1 0 0000200008 0 5a ffffffffffffffff
2 1 0000100000 1 0 ffffffffffffffff
2 0 0000100000 0 1 ffffffffffffffff
2 1 0000100000 0 0 ffffffffffffffff
3 1 0000104000 0 0 ffffffffffffffff
3 1 0000104000 ffffffffffffffff 0 ffffffffffffffff
3 0 0000104000 0 ffffffffffffffff ffffffffffffffff
3 0 000010bff8 0 0 0
3 0 000010bff8 0 0 0
4 1 0080000000 1122334455667788 0 ffffffffffffffff
4 1 0080000040 cafef00d12345678 0 ffffffffffffffff
4 0 0080000000 0 1122334455667788 ffffffffffffffff
4 0 0080000040 0 cafef00d12345678 ffffffffffffffff
4 0 00a0000100 0 0 ffffffffffffffff
4 1 ff00000008 0123456789abcdef 0 ffffffffffffffff
4 0 ff00000008 0 0123456789abcdef ffffffffffffffff
5 1 0000700040 00000000deadbeef 0 ffffffffffffffff
5 0 0000700040 0 00000000deadbeef ffffffffffffffff
5 0 0000f00000 0 0 ffffffffffffffff
6 0 0000200008 0 5a ffffffffffffffff
6 1 0080000080 55aa55aa55aa55aa 0 ffffffffffffffff
6 0 0000100000 0 0 ffffffffffffffff
6 0 0080000080 0 55aa55aa55aa55aa ffffffffffffffff
6 1 0000200000 1 0 ffffffffffffffff
6 0 0000200000 0 1 ffffffffffffffff
0 0 0 0 0 0

// File: filelist.f
common/tile_pkg.sv
common/mem_if.sv
logic/local_cmd_router.sv
clint/clint_slice.sv
cfg/cfg_regs.sv
logic/dram_port.sv
logic/tile_local_top.sv
tests/tile_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the tile-local testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tile_tb -f filelist.f -o tile_sim
./obj_dir/tile_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "No errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
